//--- flist.f
+incdir+include
src/bldc_pkg.sv
src/bldc_bus_pkg.sv
src/bldc_regs.sv
src/bldc_commutation.sv
src/bldc_serial_mult.sv
src/bldc_duty_seq.sv
src/bldc_pwm.sv
src/bldc_top.sv
tests/tb_clkgen.sv
tests/tb_bldc.sv

//--- Bender.yml
package:
  name: bldc_driver

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/bldc_pkg.sv
      - src/bldc_bus_pkg.sv
      - src/bldc_regs.sv
      - src/bldc_commutation.sv
      - src/bldc_serial_mult.sv
      - src/bldc_duty_seq.sv
      - src/bldc_pwm.sv
      - src/bldc_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tests/tb_clkgen.sv
      - tests/tb_bldc.sv

//--- tests/tb_bldc.sv
`timescale 1ns/1ps
`include "bldc_cfg.svh"

module tb_bldc import bldc_pkg::*, bldc_bus_pkg::*; ();

    localparam int CLK_NS    = 100;
    localparam int PWM_CLKS  = 512;  // 128 ticks of 4 clocks
    localparam int WDOG_CLKS = 20 * PWM_CLKS + 2000;
    localparam int ACK_LIMIT = 8;
    localparam logic [31:0] SEED = 32'h6b6e47ae;

    logic                       clk;
    logic                       arst_n;
    logic                       req;
    logic                       we;
    reg_addr_e                  addr;
    logic [`BLDC_DATA_BITS-1:0] wdata;
    logic [`BLDC_DATA_BITS-1:0] feedback;
    logic                       ack;
    logic [`BLDC_DATA_BITS-1:0] rdata;
    logic                       u_p, v_p, w_p;
    logic                       u_n, v_n, w_n;
    int                         value_errs;
    int                         other_errs;
    int                         rnd_init;

    tb_clkgen u_clk (.clk, .arst_n);

    bldc_top dut (
        .clk, .arst_n, .req, .we, .addr, .wdata, .ack, .rdata, .feedback,
        .u_p, .v_p, .w_p, .u_n, .v_n, .w_n
    );

    // ------------------------------------------------------------------
    // reference model and compare tasks
    // ------------------------------------------------------------------
    function automatic int sine_entry(int idx);
        return $rtoi(127.0 * $sin(3.14159265358979 * idx / 32.0) + 0.5);
    endfunction

    function automatic int model_duty(int pos, int volt);
        int sample;
        if (pos < 32) sample = 127 + sine_entry(pos);
        else          sample = 127 - sine_entry(pos - 32);
        return (sample * volt) >> 8;
    endfunction

    function automatic logic [5:0] gate_vec();
        return {u_p, v_p, w_p, u_n, v_n, w_n};
    endfunction

    function automatic logic [15:0] ctrl_word(logic en, mode_e m);
        return {13'd0, m, en};
    endfunction

    task automatic check_word(string name, logic [15:0] got, logic [15:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_gate(string name, logic [5:0] got, logic [5:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_count(string name, int got, int exp, int tol);
        if (got < exp - tol || got > exp + tol) begin
            $display("[ERROR] %s: got 0x%0h expected 0x%0h +/- %0d", name, got, exp, tol);
            value_errs++;
        end
    endtask

    // ------------------------------------------------------------------
    // host port, four-phase
    // ------------------------------------------------------------------
    task automatic bus_cycle(input logic wr, input reg_addr_e a, input logic [15:0] d,
                             output logic [15:0] q);
        int n;
        if (ack !== 1'b0) begin
            $display("ack was high before the request was raised");
            other_errs++;
        end
        @(posedge clk);
        req   <= 1'b1;
        we    <= wr;
        addr  <= a;
        wdata <= d;
        @(negedge clk);
        if (ack !== 1'b0) begin
            $display("ack rose before the register block could see req");
            other_errs++;
        end
        n = 0;
        while (ack !== 1'b1 && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (ack !== 1'b1) begin
            $display("no ack within %0d cycles of req", ACK_LIMIT);
            other_errs++;
        end
        q = rdata;  // valid while ack is high
        @(posedge clk);
        req <= 1'b0;
        we  <= 1'b0;
        @(negedge clk);
        if (ack !== 1'b1) begin
            $display("ack fell before the register block could see req drop");
            other_errs++;
        end
        n = 0;
        while (ack !== 1'b0 && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (ack !== 1'b0) begin
            $display("ack stayed high after req was dropped");
            other_errs++;
        end
    endtask

    task automatic bus_write(reg_addr_e a, logic [15:0] d);
        logic [15:0] unused;
        bus_cycle(1'b1, a, d, unused);
    endtask

    task automatic bus_read(reg_addr_e a, output logic [15:0] q);
        bus_cycle(1'b0, a, 16'h0000, q);
    endtask

    task automatic count_u_high(output int cnt);
        cnt = 0;
        repeat (PWM_CLKS) begin
            @(negedge clk);
            if (u_p) cnt++;
        end
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    task automatic test_reset_state();
        check_gate("gates after reset", gate_vec(), 6'h00);
        check_word("ack after reset", {15'd0, ack}, 16'h0000);
    endtask

    task automatic test_reg_roundtrip();
        logic [15:0] vel;
        logic [15:0] off;
        logic [15:0] q;
        vel = $urandom;
        off = $urandom;
        bus_write(REG_VEL, vel);
        bus_write(REG_OFFSET, off);
        bus_read(REG_VEL, q);
        check_word("rdata (VEL)", q, vel);
        bus_read(REG_OFFSET, q);
        check_word("rdata (OFFSET)", q, off);
    endtask

    task automatic test_status_read();
        logic [15:0] fb;
        logic [15:0] q;
        fb = $urandom;
        @(posedge clk);
        feedback <= fb;
        @(negedge clk);
        bus_read(REG_STATUS, q);
        check_word("rdata (STATUS)", q, fb);
    endtask

    task automatic test_disabled_gates();
        logic [5:0] seen;
        bus_write(REG_CTRL, ctrl_word(1'b0, MODE_RUN));
        bus_write(REG_VEL, 16'd200);
        seen = 6'h00;
        repeat (PWM_CLKS) begin
            @(negedge clk);
            seen = seen | gate_vec();  // any gate high at any time
        end
        check_gate("gates with enable low", seen, 6'h00);
    endtask

    task automatic test_complementary();
        logic [5:0] g;
        logic [5:0] exp;
        bus_write(REG_CTRL, ctrl_word(1'b1, MODE_RUN));
        bus_write(REG_VEL, 16'd180);
        for (int i = 0; i < 2 * PWM_CLKS; i++) begin
            @(posedge clk);
            if (i % 16 == 0) feedback <= $urandom;  // move the rotor around
            @(negedge clk);
            g   = gate_vec();
            exp = {g[5:3], ~g[5:3]};
            if (g !== exp) begin
                check_gate("gates p/n pairs", g, exp);
                break;
            end
        end
    endtask

    task automatic test_duty_ratio();
        int cnt;
        int duty;
        bus_write(REG_CTRL, ctrl_word(1'b1, MODE_POS));
        bus_write(REG_OFFSET, 16'd40);
        bus_write(REG_VEL, 16'd255);
        duty = model_duty(40, 255);
        if (duty > 128) duty = 128;  // counter saturates at a full period
        repeat (3 * PWM_CLKS) @(negedge clk);
        count_u_high(cnt);
        check_count("u_p high clocks", cnt, 4 * duty, 4);
        bus_write(REG_VEL, 16'd0);
        repeat (3 * PWM_CLKS) @(negedge clk);
        count_u_high(cnt);
        check_count("u_p high clocks at zero velocity", cnt, 0, 0);
    endtask

    // ------------------------------------------------------------------
    // watchdog and main sequence
    // ------------------------------------------------------------------
    initial begin
        #(WDOG_CLKS * CLK_NS);
        $display("watchdog expired after %0d clocks, the run did not finish", WDOG_CLKS);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rnd_init   = $urandom(SEED);
        req        = 1'b0;
        we         = 1'b0;
        addr       = REG_CTRL;
        wdata      = '0;
        feedback   = '0;
        value_errs = 0;
        other_errs = 0;
        wait (arst_n === 1'b1);
        @(negedge clk);
        test_reset_state();
        test_reg_roundtrip();
        test_status_read();
        test_disabled_gates();
        test_complementary();
        test_duty_ratio();
        $display("tb_bldc: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- tests/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic arst_n
);

    localparam int HALF_NS      = 50;  // 100 ns period
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_NS clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;  // release away from the rising edge
    end

endmodule

//--- src/bldc_top.sv
`timescale 1ns/1ps
`include "bldc_cfg.svh"

module bldc_top import bldc_pkg::*, bldc_bus_pkg::*; (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        req,
    input  logic                        we,
    input  reg_addr_e                   addr,
    input  logic [`BLDC_DATA_BITS-1:0]  wdata,
    output logic                        ack,
    output logic [`BLDC_DATA_BITS-1:0]  rdata,
    input  logic [`BLDC_DATA_BITS-1:0]  feedback,
    output logic                        u_p,
    output logic                        v_p,
    output logic                        w_p,
    output logic                        u_n,
    output logic                        v_n,
    output logic                        w_n
);

    logic                              enable;
    mode_e                             mode;
    logic signed [`BLDC_VEL_BITS-1:0]  velocity;
    logic signed [`BLDC_VEL_BITS-1:0]  offset;
    logic [`BLDC_SINE_LEN_BITS-1:0]    pos_u;
    logic [`BLDC_SINE_LEN_BITS-1:0]    pos_v;
    logic [`BLDC_SINE_LEN_BITS-1:0]    pos_w;
    logic [`BLDC_SINE_RES_BITS:0]      voltage;
    logic                              mul_req;
    logic                              mul_ack;
    logic [`BLDC_MUL_BITS-1:0]         mul_a;
    logic [`BLDC_MUL_BITS-1:0]         mul_b;
    logic [2*`BLDC_MUL_BITS-1:0]       mul_prod;
    logic [`BLDC_SINE_RES_BITS:0]      dty_u;
    logic [`BLDC_SINE_RES_BITS:0]      dty_v;
    logic [`BLDC_SINE_RES_BITS:0]      dty_w;

    bldc_regs u_regs (
        .clk, .arst_n, .req, .we, .addr, .wdata, .feedback,
        .ack, .rdata, .enable, .mode, .velocity, .offset
    );

    bldc_commutation u_comm (
        .clk, .arst_n, .mode, .velocity, .offset, .feedback,
        .pos_u, .pos_v, .pos_w, .voltage
    );

    // shared multiplier, one phase at a time
    bldc_duty_seq u_seq (
        .clk, .arst_n, .pos_u, .pos_v, .pos_w, .voltage, .mul_ack, .mul_prod,
        .mul_req, .mul_a, .mul_b, .dty_u, .dty_v, .dty_w
    );

    bldc_serial_mult u_mult (
        .clk, .arst_n, .req(mul_req), .a(mul_a), .b(mul_b),
        .ack(mul_ack), .prod(mul_prod)
    );

    bldc_pwm u_pwm (
        .clk, .arst_n, .enable, .dty_u, .dty_v, .dty_w,
        .u_p, .v_p, .w_p, .u_n, .v_n, .w_n
    );

endmodule

//--- src/bldc_pwm.sv
`timescale 1ns/1ps
`include "bldc_cfg.svh"

module bldc_pwm (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          enable,
    input  logic [`BLDC_SINE_RES_BITS:0]  dty_u,
    input  logic [`BLDC_SINE_RES_BITS:0]  dty_v,
    input  logic [`BLDC_SINE_RES_BITS:0]  dty_w,
    output logic                          u_p,
    output logic                          v_p,
    output logic                          w_p,
    output logic                          u_n,
    output logic                          v_n,
    output logic                          w_n
);

    localparam int CNT_BITS = `BLDC_SINE_RES_BITS - 1;  // 128 ticks per period
    localparam int DTY_BITS = `BLDC_SINE_RES_BITS + 1;
    localparam int PRE_BITS = $clog2(`BLDC_PWM_DIV + 1);

    logic [PRE_BITS-1:0] pre_cnt;
    logic                tick;
    logic [DTY_BITS-1:0] dty [3];
    logic [2:0]          pulse;

    assign dty[0] = dty_u;
    assign dty[1] = dty_v;
    assign dty[2] = dty_w;
    assign tick   = (pre_cnt == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) pre_cnt <= '0;
        else if (tick) pre_cnt <= PRE_BITS'(`BLDC_PWM_DIV);
        else pre_cnt <= pre_cnt - 1'b1;
    end

    // ----------------------------------------------------------------------
    // per phase counter and pulse
    // ----------------------------------------------------------------------
    for (genvar ch = 0; ch < 3; ch++) begin : g_ch
        logic [CNT_BITS-1:0] cnt;
        logic                pulse_r;

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                cnt     <= '0;
                pulse_r <= 1'b0;
            end else if (tick) begin
                if (dty[ch] == '0) begin
                    pulse_r <= 1'b0;  // counter holds
                end else if (cnt == '1) begin
                    cnt     <= '0;
                    pulse_r <= 1'b1;  // new period
                end else begin
                    cnt <= cnt + 1'b1;
                    if (DTY_BITS'(cnt) >= dty[ch]) pulse_r <= 1'b0;
                end
            end
        end

        assign pulse[ch] = pulse_r;
    end

    assign u_p = pulse[0] & enable;
    assign v_p = pulse[1] & enable;
    assign w_p = pulse[2] & enable;
    assign u_n = ~pulse[0] & enable;
    assign v_n = ~pulse[1] & enable;
    assign w_n = ~pulse[2] & enable;

endmodule

//--- src/bldc_duty_seq.sv
`timescale 1ns/1ps
`include "bldc_cfg.svh"

module bldc_duty_seq import bldc_pkg::*; (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [`BLDC_SINE_LEN_BITS-1:0]   pos_u,
    input  logic [`BLDC_SINE_LEN_BITS-1:0]   pos_v,
    input  logic [`BLDC_SINE_LEN_BITS-1:0]   pos_w,
    input  logic [`BLDC_SINE_RES_BITS:0]     voltage,
    input  logic                             mul_ack,
    input  logic [2*`BLDC_MUL_BITS-1:0]      mul_prod,
    output logic                             mul_req,
    output logic [`BLDC_MUL_BITS-1:0]        mul_a,
    output logic [`BLDC_MUL_BITS-1:0]        mul_b,
    output logic [`BLDC_SINE_RES_BITS:0]     dty_u,
    output logic [`BLDC_SINE_RES_BITS:0]     dty_v,
    output logic [`BLDC_SINE_RES_BITS:0]     dty_w
);

    localparam int TBL_LEN = 1 << (`BLDC_SINE_LEN_BITS - 1);  // half wave
    localparam int CENTER  = (1 << `BLDC_SINE_RES_BITS) / 2 - 1;
    localparam int HALF    = `BLDC_SINE_LEN_BITS - 1;

    typedef logic [`BLDC_SINE_RES_BITS-1:0] sine_t;
    typedef sine_t sine_tbl_t [TBL_LEN];

    // round(127 * sin(pi * i / 32)), evaluated at elaboration
    function automatic sine_tbl_t build_sine_tbl();
        sine_tbl_t tbl;
        real       ang;
        for (int i = 0; i < TBL_LEN; i++) begin
            ang    = 3.14159265358979 * i / TBL_LEN;
            tbl[i] = sine_t'($rtoi(CENTER * $sin(ang) + 0.5));
        end
        return tbl;
    endfunction

    localparam sine_tbl_t SINE_TBL = build_sine_tbl();

    seq_state_e                      state;
    phase_e                          phase;
    logic [`BLDC_SINE_LEN_BITS-1:0]  cur_pos;
    sine_t                           sample;
    logic [`BLDC_SINE_RES_BITS:0]    duty;
    logic                            load;

    always_comb begin
        case (phase)
            PH_V:    cur_pos = pos_v;
            PH_W:    cur_pos = pos_w;
            default: cur_pos = pos_u;
        endcase
        if (cur_pos[HALF]) sample = sine_t'(CENTER) - SINE_TBL[cur_pos[HALF-1:0]];
        else               sample = sine_t'(CENTER) + SINE_TBL[cur_pos[HALF-1:0]];
    end

    assign duty = mul_prod[`BLDC_VEL_RANGE_LOG2 +: `BLDC_SINE_RES_BITS+1];
    assign load = (state == SEQ_LOAD) && !mul_ack;  // previous ack has fallen

    // ----------------------------------------------------------------------
    // round robin over u, v, w, four cycles per phase
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= SEQ_LOAD;
            phase   <= PH_U;
            mul_req <= 1'b0;
            dty_u   <= '0;
            dty_v   <= '0;
            dty_w   <= '0;
        end else begin
            case (state)
                SEQ_LOAD: begin
                    if (load) begin
                        mul_req <= 1'b1;
                        state   <= SEQ_WAIT;
                    end
                end
                SEQ_WAIT: begin
                    if (mul_ack) begin
                        mul_req <= 1'b0;
                        state   <= SEQ_DROP;
                        case (phase)
                            PH_V:    dty_v <= duty;
                            PH_W:    dty_w <= duty;
                            default: dty_u <= duty;
                        endcase
                    end
                end
                default: begin
                    state <= SEQ_LOAD;
                    phase <= (phase == PH_W) ? PH_U : phase_e'(phase + 2'd1);
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin  // operands stay put while req is high
            mul_a <= `BLDC_MUL_BITS'(sample);
            mul_b <= `BLDC_MUL_BITS'(voltage);
        end
    end

    // multiplier only acks a pending request
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!arst_n) !mul_req && !mul_ack |=> !mul_ack);

endmodule

//--- src/bldc_serial_mult.sv
`timescale 1ns/1ps
`include "bldc_cfg.svh"

module bldc_serial_mult (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          req,
    input  logic [`BLDC_MUL_BITS-1:0]     a,
    input  logic [`BLDC_MUL_BITS-1:0]     b,
    output logic                          ack,
    output logic [2*`BLDC_MUL_BITS-1:0]   prod
);

    // ack follows req by one clock in both directions
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req && !ack) begin
            prod <= a * b;  // stable until the next request
        end
    end

endmodule

//--- src/bldc_commutation.sv
`timescale 1ns/1ps
`include "bldc_cfg.svh"

module bldc_commutation import bldc_pkg::*; (
    input  logic                              clk,
    input  logic                              arst_n,
    input  mode_e                             mode,
    input  logic signed [`BLDC_VEL_BITS-1:0]  velocity,
    input  logic signed [`BLDC_VEL_BITS-1:0]  offset,
    input  logic [`BLDC_DATA_BITS-1:0]        feedback,
    output logic [`BLDC_SINE_LEN_BITS-1:0]    pos_u,
    output logic [`BLDC_SINE_LEN_BITS-1:0]    pos_v,
    output logic [`BLDC_SINE_LEN_BITS-1:0]    pos_w,
    output logic [`BLDC_SINE_RES_BITS:0]      voltage
);

    localparam int VB = `BLDC_SINE_RES_BITS + 1;

    typedef logic [`BLDC_SINE_LEN_BITS-1:0] pos_t;

    localparam pos_t TOFF_V = pos_t'(`BLDC_TOFF_V);
    localparam pos_t TOFF_W = pos_t'(`BLDC_TOFF_W);
    localparam pos_t TMAX_P = pos_t'(`BLDC_TMAX);
    localparam pos_t TMAX_N = pos_t'(-`BLDC_TMAX);  // wraps modulo 64
    localparam logic [`BLDC_VEL_BITS:0] VMAX = (1 << VB) - 1;

    pos_t                             tangle;
    pos_t                             fb_pos;
    pos_t                             off_pos;
    pos_t                             rotor;
    logic signed [`BLDC_VEL_BITS:0]   vel_ext;
    logic [`BLDC_VEL_BITS:0]          vel_abs;

    assign fb_pos  = feedback[`BLDC_FB_DIV_LOG2 +: `BLDC_SINE_LEN_BITS];
    assign off_pos = offset[`BLDC_SINE_LEN_BITS-1:0];
    assign rotor   = fb_pos + off_pos + tangle;
    assign vel_ext = velocity;  // one extra bit so -32768 has a magnitude
    assign vel_abs = vel_ext[`BLDC_VEL_BITS] ? -vel_ext : vel_ext;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tangle  <= '0;
            pos_u   <= '0;
            pos_v   <= '0;
            pos_w   <= '0;
            voltage <= '0;
        end else begin
            if (mode == MODE_CAL || velocity == 0) tangle <= '0;
            else if (velocity > 0)                 tangle <= TMAX_P;
            else                                   tangle <= TMAX_N;

            if (mode == MODE_POS) begin  // no feedback
                pos_u <= off_pos;
                pos_v <= off_pos + TOFF_V;
                pos_w <= off_pos + TOFF_W;
            end else begin
                pos_u <= rotor;
                pos_v <= rotor + TOFF_V;
                pos_w <= rotor + TOFF_W;
            end

            voltage <= (vel_abs > VMAX) ? '1 : vel_abs[VB-1:0];  // saturate
        end
    end

endmodule

//--- src/bldc_regs.sv
`timescale 1ns/1ps
`include "bldc_cfg.svh"

module bldc_regs import bldc_pkg::*, bldc_bus_pkg::*; (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             req,
    input  logic                             we,
    input  reg_addr_e                        addr,
    input  logic [`BLDC_DATA_BITS-1:0]       wdata,
    input  logic [`BLDC_DATA_BITS-1:0]       feedback,
    output logic                             ack,
    output logic [`BLDC_DATA_BITS-1:0]       rdata,
    output logic                             enable,
    output mode_e                            mode,
    output logic signed [`BLDC_VEL_BITS-1:0] velocity,
    output logic signed [`BLDC_VEL_BITS-1:0] offset
);

    bus_state_e                 state;
    logic [`BLDC_DATA_BITS-1:0] rd_mux;
    logic                       req_new;

    assign ack     = (state == BUS_ACK);  // registered through the state
    assign req_new = (state == BUS_IDLE) && req;

    always_comb begin
        rd_mux = '0;
        case (addr)
            REG_CTRL:   rd_mux[2:0] = {mode, enable};
            REG_VEL:    rd_mux = velocity;
            REG_OFFSET: rd_mux = offset;
            default:    rd_mux = feedback;
        endcase
    end

    // ----------------------------------------------------------------------
    // four-phase handshake and control registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= BUS_IDLE;
            enable   <= 1'b0;
            mode     <= MODE_RUN;
            velocity <= '0;
            offset   <= '0;
        end else begin
            case (state)
                BUS_IDLE: if (req) state <= BUS_ACK;
                default:  if (!req) state <= BUS_IDLE;  // ack falls next edge
            endcase
            if (req_new && we) begin
                case (addr)
                    REG_CTRL: begin
                        enable <= wdata[0];
                        mode   <= mode_e'(wdata[2:1]);
                    end
                    REG_VEL:    velocity <= wdata;
                    REG_OFFSET: offset   <= wdata;
                    default:    ;  // status is read only
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_new) rdata <= rd_mux;  // held while ack is high
    end

    // host keeps req and its fields steady until ack
    a_req_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        req && !ack |=> req && $stable({we, addr, wdata}));

endmodule

//--- src/bldc_bus_pkg.sv
`include "bldc_cfg.svh"

package bldc_bus_pkg;

    typedef enum logic [`BLDC_ADDR_BITS-1:0] {
        REG_CTRL   = 2'd0,  // bit 0 enable, bits 2:1 mode
        REG_VEL    = 2'd1,
        REG_OFFSET = 2'd2,
        REG_STATUS = 2'd3   // read only, feedback
    } reg_addr_e;

    typedef enum logic {
        BUS_IDLE = 1'b0,
        BUS_ACK  = 1'b1
    } bus_state_e;

endpackage

//--- src/bldc_pkg.sv
package bldc_pkg;

    // drive mode, ctrl register bits 2:1
    typedef enum logic [1:0] {
        MODE_RUN = 2'd0,  // feedback drives the rotor angle
        MODE_POS = 2'd1,  // open loop position
        MODE_CAL = 2'd2   // zero torque angle
    } mode_e;

    // duty sequencer, one pass per phase
    typedef enum logic [1:0] {
        SEQ_LOAD = 2'd0,
        SEQ_WAIT = 2'd1,
        SEQ_DROP = 2'd2
    } seq_state_e;

    typedef enum logic [1:0] {
        PH_U = 2'd0,
        PH_V = 2'd1,
        PH_W = 2'd2
    } phase_e;

endpackage

//--- include/bldc_cfg.svh
`ifndef BLDC_CFG_SVH
`define BLDC_CFG_SVH

// ----------------------------------------------------------------------
// sine table and duty resolution
// ----------------------------------------------------------------------
`define BLDC_SINE_LEN_BITS  6   // 64 positions per electrical turn
`define BLDC_SINE_RES_BITS  8   // duty width
`define BLDC_VEL_RANGE_LOG2 8   // duty = product >> this

// ----------------------------------------------------------------------
// control and feedback
// ----------------------------------------------------------------------
`define BLDC_VEL_BITS       16  // velocity and offset
`define BLDC_FB_DIV_LOG2    4   // feedback / 16
`define BLDC_TOFF_V         20  // phase v offset
`define BLDC_TOFF_W         41  // phase w offset
`define BLDC_TMAX           15  // quarter turn minus one

`define BLDC_PWM_DIV        3   // tick every 4 clocks
`define BLDC_ADDR_BITS      2
`define BLDC_DATA_BITS      16  // host data and feedback
`define BLDC_MUL_BITS       16  // multiplier operand width

`endif
